//--- src.f
common/lcdPkg.sv
verilog/levelPwm.sv
verilog/phaseSequencer.sv
lcd/segmentMapper.sv
lcd/lcdDriver.sv
sim/lcdDriverTb.sv

//--- run.sh
#!/bin/sh
# Builds the LCD driver testbench with Verilator and runs it; fails unless the pass line appears
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module lcdDriverTb \
	-f src.f -o lcdDriverSim || { echo "Build failed"; exit 1; }
simOut="$(./obj_dir/lcdDriverSim)"
printf '%s\n' "$simOut"
printf '%s\n' "$simOut" | grep -Fqx '>>> PASS' \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

//--- sim/lcdDriverTb.sv
// Self-checking testbench for the LCD driver; compile with src.f from the project root, top lcdDriverTb
module lcdDriverTb
	import lcdPkg::*;
();

	localparam logic [31:0] Seed = 32'haebb_58d2;
	localparam logic [31:0] LfsrTaps = 32'h8020_0003;	// x^32 + x^22 + x^2 + x + 1
	localparam int WaitLimit = 9 * PhaseCycles;	// Longer than one frame
	localparam int LengthSlack = 2;	// Sliding window blurs each edge by a cycle
	localparam int BalanceSum = 12;	// Per pin over one frame
	localparam int Frames = 3;

	logic Clock;
	logic Reset;
	displayT display;
	pinsT pins;

	logic [31:0] lfsr;
	pinsT history [3];	// Last three pin samples, newest first
	levelT winLevel [36:1];	// High count over the window
	phaseT winPhase;	// Phase decoded from the COM pins
	logic winValid;	// Exactly one COM at a rail
	int pinSum [36:1];	// Level sum over the measured phases
	int levelErrors;
	int phaseErrors;
	int countErrors;

	lcdDriver dut_i (
		.Clock     (Clock),
		.Reset     (Reset),
		.display_i (display),
		.pins_o    (pins)
	);

	initial begin
		Clock = 1'b0;
		forever #4 Clock = ~Clock;
	end

	// One LFSR step per bit taken
	function automatic logic randomBit();
		logic out;
		out = lfsr[0];
		lfsr = lfsr >> 1;
		if (out) begin
			lfsr = lfsr ^ LfsrTaps;
		end
		return out;
	endfunction

	function automatic displayT randomDisplay();
		displayT d;
		for (int i = 0; i < $bits(displayT); i++) begin
			d[i] = randomBit();
		end
		return d;
	endfunction

	// Segment pins run 2..17, then 20..35
	function automatic int pinOfIndex(input int idx);
		return (idx < 16) ? idx + 2 : idx + 4;
	endfunction

	function automatic phaseT nextPhase(input phaseT ph);
		return (ph == Com3L) ? Com0H : phaseT'(int'(ph) + 1);
	endfunction

	// Expected bias level of one pin, from the pin map and the bias table
	function automatic levelT modelLevel(input displayT d, input phaseT ph, input int pin);
		int bp;
		logic low;
		int idx;
		int k;
		segmentsT ch;
		bp = int'(ph) % Backplanes;
		low = (int'(ph) >= Backplanes);
		for (int b = 0; b < Backplanes; b++) begin
			if (pin == ComPins[b]) begin
				if (b == bp) begin
					return low ? ActiveComL : ActiveComH;
				end
				return low ? InactiveComL : InactiveComH;
			end
		end
		idx = (pin < 18) ? pin - 2 : pin - 4;
		ch = d[SegsPerChar * (idx / 4) +: SegsPerChar];	// Character idx div 4
		k = 4 * (idx % 4) + bp;	// Bit on this backplane at this offset
		if (k == 15 || !ch[k]) begin
			return low ? InactiveSegL : InactiveSegH;	// Off, or the empty slot
		end
		return low ? ActiveSegL : ActiveSegH;
	endfunction

	task automatic printCounts();
		$display("Errors: level %0d, phase %0d, count %0d", levelErrors, phaseErrors, countErrors);
	endtask

	task automatic abortRun(input string why);
		$display("Run stopped: %s", why);
		printCounts();
		$display(">>> FAIL");
		$finish;
	endtask

	task automatic checkLevel(input string name, input levelT exp, input levelT act);
		if (exp !== act) begin
			levelErrors++;
			$display("ERR %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic checkPhase(input string name, input phaseT exp, input phaseT act);
		if (exp !== act) begin
			phaseErrors++;
			$display("ERR %s expected %s actual %s", name, exp.name(), act.name());
		end
	endtask

	task automatic checkCount(input string name, input int exp, input int act);
		if (exp != act) begin
			countErrors++;
			$display("ERR %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic checkLength(input int len);
		if (len < PhaseCycles - LengthSlack || len > PhaseCycles + LengthSlack) begin
			countErrors++;
			$display("ERR phaseLength expected %0d actual %0d", PhaseCycles, len);
		end
	endtask

	// Sample at the falling edge, pins settle on the rising one
	task automatic sampleCycle();
		int rails;
		@(negedge Clock);
		history[2] = history[1];
		history[1] = history[0];
		history[0] = pins;
		for (int p = 1; p <= 36; p++) begin
			winLevel[p] = levelT'(history[0][p]) + levelT'(history[1][p]) + levelT'(history[2][p]);
		end
		rails = 0;
		winPhase = Com0H;
		for (int b = 0; b < Backplanes; b++) begin
			if (winLevel[ComPins[b]] == 2'd3 || winLevel[ComPins[b]] == 2'd0) begin
				rails++;
				winPhase = phaseT'(b + ((winLevel[ComPins[b]] == 2'd0) ? 4 : 0));	// Rail 0 is low half
			end
		end
		winValid = (rails == 1);
	endtask

	task automatic measureWindow();
		repeat (3) sampleCycle();	// Fresh window, no old samples
	endtask

	task automatic waitForDecode(input phaseT target, input logic anyPhase);
		int cycles;
		logic found;
		cycles = 0;
		found = 1'b0;
		while (!found && cycles < WaitLimit) begin
			sampleCycle();
			cycles++;
			found = winValid && (anyPhase || winPhase == target);
		end
		if (!found) begin
			abortRun($sformatf("no phase %s within %0d cycles", target.name(), WaitLimit));
		end
	endtask

	task automatic driveDisplay(input displayT d);
		@(posedge Clock);
		#1 display = d;
	endtask

	task automatic measurePhase(input phaseT ph, input displayT d);
		int p;
		waitForDecode(ph, 1'b0);
		sampleCycle();	// First decode may still hold a sample of the old phase
		measureWindow();
		if (!winValid) begin
			phaseErrors++;
			$display("No single active COM inside phase %s", ph.name());
		end
		checkPhase("phaseSeen", ph, winPhase);
		for (p = 1; p <= 36; p++) begin
			checkLevel($sformatf("pin %0d in %s", p, ph.name()), modelLevel(d, ph, p), winLevel[p]);
			pinSum[p] += int'(winLevel[p]);
		end
		if (ph == Com3H || ph == Com3L) begin
			for (int c = 0; c < CharCount; c++) begin
				p = pinOfIndex(4 * c + 3);	// Last pin of character c
				checkLevel($sformatf("unusedSlot char %0d in %s", c, ph.name()),
					(ph == Com3H) ? InactiveSegH : InactiveSegL, winLevel[p]);
			end
		end
	endtask

	// Counts cycles between first decodes of consecutive phases
	task automatic checkPhaseOrder(input int frames);
		phaseT prev;
		int sinceChange;
		int changes;
		logic started;
		waitForDecode(Com0H, 1'b1);
		prev = winPhase;
		sinceChange = 0;
		changes = 0;
		started = 1'b0;
		while (changes < frames * 8) begin
			sampleCycle();
			sinceChange++;
			if (winValid && winPhase != prev) begin
				checkPhase("phaseOrder", nextPhase(prev), winPhase);
				if (started) begin
					checkLength(sinceChange);
				end
				started = 1'b1;	// First run may have begun before the wait
				prev = winPhase;
				sinceChange = 0;
				changes++;
			end else if (sinceChange > 2 * PhaseCycles) begin
				abortRun($sformatf("phase stuck at %s", prev.name()));
			end
		end
	endtask

	initial begin
		displayT first;
		displayT second;
		Reset = 1'b0;
		display = '0;
		lfsr = Seed;
		levelErrors = 0;
		phaseErrors = 0;
		countErrors = 0;
		for (int i = 0; i < 3; i++) begin
			history[i] = '0;
		end
		for (int p = 1; p <= 36; p++) begin
			pinSum[p] = 0;
		end

		// All pins low while in reset
		repeat (8) @(posedge Clock);
		measureWindow();
		for (int p = 1; p <= 36; p++) begin
			checkLevel($sformatf("reset pin %0d", p), 2'd0, winLevel[p]);
		end
		repeat (6) @(posedge Clock);	// Sixteen cycles in all
		#1 Reset = 1'b1;

		waitForDecode(Com0H, 1'b1);
		checkPhase("firstPhase", Com0H, winPhase);

		checkPhaseOrder(Frames);

		// Bitmap held for a whole frame
		for (int f = 0; f < Frames; f++) begin
			waitForDecode(Com3L, 1'b0);
			first = randomDisplay();
			driveDisplay(first);	// Lands before the next Com0H
			for (int p = 1; p <= 36; p++) begin
				pinSum[p] = 0;
			end
			for (int ph = 0; ph < 8; ph++) begin
				measurePhase(phaseT'(ph), first);
			end
			for (int p = 1; p <= 36; p++) begin
				checkCount($sformatf("balance pin %0d", p), BalanceSum, pinSum[p]);
			end
		end

		// New bitmap mid-frame
		waitForDecode(Com3L, 1'b0);
		first = randomDisplay();
		driveDisplay(first);
		measurePhase(Com0H, first);
		measurePhase(Com1H, first);
		second = randomDisplay();
		driveDisplay(second);	// Still inside Com1H
		for (int ph = 2; ph < 10; ph++) begin
			measurePhase(phaseT'(ph % 8), second);
		end

		printCounts();
		if (levelErrors + phaseErrors + countErrors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- lcd/lcdDriver.sv
// Top of the LCD glass driver; takes eight character bitmaps and drives the 36 PWM glass pins
module lcdDriver
	import lcdPkg::*;
(
	input  logic    Clock,
	input  logic    Reset,
	input  displayT display_i,	// Bitmaps, char0 rightmost
	output pinsT    pins_o	// Each pin needs an RC filter
);

	phaseT phase;	// Current drive phase
	pwmLevelsT levels;	// Four bias waveforms

	phaseSequencer phaseSequencer_i (
		.Clock_i (Clock),
		.Reset_i (Reset),
		.phase_o (phase)
	);

	levelPwm levelPwm_i (
		.Clock_i  (Clock),
		.Reset_i  (Reset),
		.levels_o (levels)
	);

	// Routes the bias waves to COM and segment pins
	segmentMapper segmentMapper_i (
		.Clock_i   (Clock),
		.Reset_i   (Reset),
		.phase_i   (phase),
		.levels_i  (levels),
		.display_i (display_i),
		.pins_o    (pins_o)
	);

endmodule

//--- lcd/segmentMapper.sv
// Pin level mapper; picks a bias level per glass pin from phase and bitmaps and registers its PWM wave
module segmentMapper
	import lcdPkg::*;
(
	input  logic      Clock_i,
	input  logic      Reset_i,
	input  phaseT     phase_i,
	input  pwmLevelsT levels_i,
	input  displayT   display_i,
	output pinsT      pins_o
);

	backplaneT backplane;	// COM driven active this phase
	logic lowHalf;	// Second half of the frame
	levelT activeCom;
	levelT inactiveCom;
	levelT activeSeg;
	levelT inactiveSeg;

	segmentsT [CharCount-1:0] chars;	// chars[0] is the rightmost character
	logic [3:0] levelWaves;	// Waveform indexed by level number
	levelT pinLevel [36:1];	// Chosen level for every pin

	// Sequential phase encoding
	assign backplane = phase_i[1:0];
	assign lowHalf = phase_i[2];

	assign activeCom = lowHalf ? ActiveComL : ActiveComH;
	assign inactiveCom = lowHalf ? InactiveComL : InactiveComH;
	assign activeSeg = lowHalf ? ActiveSegL : ActiveSegH;
	assign inactiveSeg = lowHalf ? InactiveSegL : InactiveSegH;

	assign chars = display_i;	// char7 sits in the top bits
	assign levelWaves = levels_i;	// level3 sits in bit 3

	always_comb begin
		int k;	// Segment bit of the current slot
		int idx;	// Segment pin index 0..31

		for (int p = 1; p <= 36; p++) begin
			pinLevel[p] = inactiveSeg;	// Overwritten below
		end

		// Common pins
		for (int b = 0; b < Backplanes; b++) begin
			if (backplaneT'(b) == backplane) begin
				pinLevel[ComPins[b]] = activeCom;
			end else begin
				pinLevel[ComPins[b]] = inactiveCom;
			end
		end

		// Segment pins
		// Each character owns four pins, each pin four segments,
		// one per backplane
		for (int c = 0; c < CharCount; c++) begin
			for (int o = 0; o < PinsPerChar; o++) begin
				k = Backplanes * o + int'(backplane);
				idx = PinsPerChar * c + o;
				if (k == UnusedSlot) begin
					pinLevel[segPin(idx)] = inactiveSeg;	// No segment there
				end else if (chars[c][k[3:0]]) begin
					pinLevel[segPin(idx)] = activeSeg;	// Segment on
				end else begin
					pinLevel[segPin(idx)] = inactiveSeg;	// Segment off
				end
			end
		end
	end

	// One cycle from phase, wave and bitmap to the pins
	always_ff @(posedge Clock_i, negedge Reset_i) begin
		if (!Reset_i) begin
			pins_o <= '0;
		end else begin
			for (int p = 1; p <= 36; p++) begin
				pins_o[p] <= levelWaves[pinLevel[p]];
			end
		end
	end

	// Exactly one COM sits at a rail level in every phase
	oneActiveCom: assert property (
		@(posedge Clock_i) disable iff (!Reset_i)
		$onehot({
			pinLevel[ComPins[3]] inside {2'd0, 2'd3},
			pinLevel[ComPins[2]] inside {2'd0, 2'd3},
			pinLevel[ComPins[1]] inside {2'd0, 2'd3},
			pinLevel[ComPins[0]] inside {2'd0, 2'd3}
		})
	);

endmodule

//--- verilog/phaseSequencer.sv
// Common-phase sequencer; divides the clock to the COM change period and steps the eight drive phases
module phaseSequencer
	import lcdPkg::*;
(
	input  logic  Clock_i,
	input  logic  Reset_i,
	output phaseT phase_o
);

	dividerT divider;	// Clocks spent in the current phase
	phaseT phase;
	logic lastCount;	// Phase step strobe

	assign lastCount = (divider == dividerT'(PhaseCycles - 1));

	always_ff @(posedge Clock_i, negedge Reset_i) begin
		if (!Reset_i) begin
			divider <= '0;
		end else if (lastCount) begin
			divider <= '0;
		end else begin
			divider <= divider + 1'b1;
		end
	end

	// Four backplanes in the high half, then the same four in the low half,
	// so each pin spends as much time above as below mid supply
	always_ff @(posedge Clock_i, negedge Reset_i) begin
		if (!Reset_i) begin
			phase <= Com0H;
		end else if (lastCount) begin
			phase <= phaseT'(phase + 3'd1);	// Com3L wraps to Com0H
		end
	end

	assign phase_o = phase;

	// Phase moves to the next enum value on the strobe
	phaseAdvance: assert property (
		@(posedge Clock_i) disable iff (!Reset_i)
		lastCount |=> phase == phaseT'($past(phase) + 3'd1)
	);

	// And holds everywhere else
	phaseHold: assert property (
		@(posedge Clock_i) disable iff (!Reset_i)
		!lastCount |=> $stable(phase)
	);

endmodule

//--- verilog/levelPwm.sv
// Bias-level PWM source; feeds the four level waveforms to the pin mapper, filtered off chip by RC
module levelPwm
	import lcdPkg::*;
(
	input  logic      Clock_i,
	input  logic      Reset_i,
	output pwmLevelsT levels_o
);

	pwmStepT step;	// Position inside the PWM period
	logic lastStep;

	assign lastStep = (step == pwmStepT'(PwmSteps - 1));

	always_ff @(posedge Clock_i, negedge Reset_i) begin
		if (!Reset_i) begin
			step <= '0;
		end else if (lastStep) begin
			step <= '0;	// Period is PwmSteps clocks
		end else begin
			step <= step + 1'b1;
		end
	end

	// Duty of level n is n thirds
	always_comb begin
		levels_o.level0 = 1'b0;	// Never high
		levels_o.level1 = (step == pwmStepT'(0));	// Step 0 only
		levels_o.level2 = (step < pwmStepT'(2));	// Steps 0 and 1
		levels_o.level3 = 1'b1;	// Always high
	end

	// Rail levels carry no PWM at all
	railLevels: assert property (
		@(posedge Clock_i) disable iff (!Reset_i)
		!levels_o.level0 && levels_o.level3
	);

	// Level 1 is high exactly once per period
	level1Once: assert property (
		@(posedge Clock_i) disable iff (!Reset_i)
		levels_o.level1 |=> !levels_o.level1 [*PwmSteps-1] ##1 levels_o.level1
	);

endmodule

//--- common/lcdPkg.sv
// Shared types, bias levels, pin map and timing constants, imported by every LCD driver block
package lcdPkg;

	localparam int ClockHz = 10_000_000;	// System clock
	localparam int ComChangeUs = 3;	// Time each common phase lasts
	localparam int PhaseCycles = ClockHz / 1_000_000 * ComChangeUs;	// 30 clocks per phase
	localparam int DividerBits = $clog2(PhaseCycles);

	localparam int PwmSteps = 3;	// Three steps give four duty levels
	localparam int PwmStepBits = $clog2(PwmSteps);

	localparam int CharCount = 8;	// Characters on the glass
	localparam int SegsPerChar = 15;	// Segments a to p, no i
	localparam int Backplanes = 4;	// COM0 to COM3
	localparam int SegPinCount = 32;	// Segment pins, four per character
	localparam int PinsPerChar = SegPinCount / CharCount;
	localparam int UnusedSlot = 15;	// Backplane 3, offset 3 has no segment

	typedef logic [SegsPerChar-1:0] segmentsT;	// Bit k is segment k, a at bit 0
	typedef logic [1:0] levelT;	// Bias level in thirds of the supply
	typedef logic [1:0] backplaneT;	// Active COM number
	typedef logic [36:1] pinsT;	// Glass pins, numbered as on the datasheet
	typedef logic [DividerBits-1:0] dividerT;
	typedef logic [PwmStepBits-1:0] pwmStepT;

	// Rightmost character is char0
	typedef struct packed {
		segmentsT char7;
		segmentsT char6;
		segmentsT char5;
		segmentsT char4;
		segmentsT char3;
		segmentsT char2;
		segmentsT char1;
		segmentsT char0;
	} displayT;

	typedef struct packed {
		logic level3;	// Full supply
		logic level2;	// Two thirds
		logic level1;	// One third
		logic level0;	// Ground
	} pwmLevelsT;

	// Low two bits give the backplane, top bit the half
	typedef enum logic [2:0] {
		Com0H,
		Com1H,
		Com2H,
		Com3H,
		Com0L,
		Com1L,
		Com2L,
		Com3L
	} phaseT;

	localparam int ComPins [Backplanes] = '{19, 36, 18, 1};	// COM0 to COM3

	// High half of the frame
	localparam levelT ActiveComH = 2'd3;
	localparam levelT InactiveComH = 2'd1;
	localparam levelT ActiveSegH = 2'd0;
	localparam levelT InactiveSegH = 2'd2;

	// Low half mirrors the high half
	localparam levelT ActiveComL = 2'd0;
	localparam levelT InactiveComL = 2'd2;
	localparam levelT ActiveSegL = 2'd3;
	localparam levelT InactiveSegL = 2'd1;

	// Segment pin index 0..31 to glass pin, skipping COM pins 18 and 19
	function automatic int segPin(input int index);
		return (index < 16) ? index + 2 : index + 4;
	endfunction

endpackage
